// ==== dataPath.f ====
dataPathPkg.sv
registerFile.sv
specialRegisters.sv
aluUnit.sv
busMux.sv
dataPath.sv
dataPathTb.sv

// ==== Bender.yml ====
package:
  name: dataPath

sources:
  - dataPathPkg.sv
  - registerFile.sv
  - specialRegisters.sv
  - aluUnit.sv
  - busMux.sv
  - dataPath.sv
  - target: simulation
    files:
      - dataPathTb.sv

// ==== dataPathTb.sv ====
module dataPathTb;

    import dataPathPkg::*;

    localparam int halfPeriod = 20;
    localparam int driveDelay = 2;
    localparam int resetCycles = 16;
    localparam int timeLimit = 100000;

    logic     Clock;
    logic     rst;
    dataWord  memData;
    logic     read;
    logic     incPc;
    aluOp     opcode;
    regSelect regIn;
    regSelect regOut;
    logic     pcOut;
    logic     mdrOut;
    logic     zHighOut;
    logic     zLowOut;
    logic     hiOut;
    logic     loOut;
    logic     pcIn;
    logic     irIn;
    logic     marIn;
    logic     mdrIn;
    logic     yIn;
    logic     zIn;
    logic     hiIn;
    logic     loIn;
    dataWord  busValue;
    dataWord  memAddress;

    // Register contents as loaded through the bus so far
    dataWord  regModel [numRegs];
    dataWord  pcModel;
    dataWord  expBus;
    logic     checkBus;
    dataWord  expAddr;
    logic     checkAddr;
    int       busErrors;
    int       addrErrors;
    aluOp     opList [11] = '{opAdd, opSub, opAnd, opOr, opShr, opShl,
                              opRor, opRol, opMul, opNeg, opNot};

    dataPath dut0 (.*);

    always #halfPeriod Clock = ~Clock;

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    busMatchesModel: assert property (
        @(posedge Clock) checkBus |-> (busValue == expBus)
    ) else begin
        busErrors++;
        $display("error at %0t: busValue expected %h actual %h",
                 $time, $sampled(expBus), $sampled(busValue));
    end

    addressMatchesModel: assert property (
        @(posedge Clock) checkAddr |-> (memAddress == expAddr)
    ) else begin
        addrErrors++;
        $display("error at %0t: memAddress expected %h actual %h",
                 $time, $sampled(expAddr), $sampled(memAddress));
    end

    function automatic wideWord productOf(input dataWord a, input dataWord b);
        longint signedA;
        longint signedB;
        signedA = $signed(a);
        signedB = $signed(b);
        return wideWord'(signedA * signedB);
    endfunction

    // Z low for each opcode, with Y as A and the bus as B
    function automatic dataWord aluExpected(input aluOp op, input dataWord a,
                                            input dataWord b);
        logic [63:0] doubled;
        wideWord     wide;
        int          amount;
        dataWord     result;
        doubled = {a, a};
        amount = b[4:0];
        wide = productOf(a, b);
        case (op)
            opAdd: result = a + b;
            opSub: result = a - b;
            opAnd: result = a & b;
            opOr: result = a | b;
            opShr: result = a >> amount;
            opShl: result = a << amount;
            opRor: result = doubled[amount +: 32];
            opRol: result = doubled[(32 - amount) +: 32];
            opMul: result = wide[31:0];
            opNeg: result = 32'd0 - b;
            opNot: result = ~b;
            default: result = '0;
        endcase
        return result;
    endfunction

    // ------------------------------------------------------------
    // Control steps
    // ------------------------------------------------------------
    task automatic clearControls();
        {read, incPc, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut} = '0;
        {pcIn, irIn, marIn, mdrIn, yIn, zIn, hiIn, loIn} = '0;
        opcode = '0;
        regIn = '0;
        regOut = '0;
        checkBus = 1'b0;
        checkAddr = 1'b0;
    endtask

    task automatic expectBus(input dataWord value);
        expBus = value;
        checkBus = 1'b1;
    endtask

    // Strobes stay up for one cycle and drop just after the edge
    task automatic endStep();
        @(posedge Clock);
        #driveDelay;
        clearControls();
    endtask

    task automatic readRegister(input int n);
        regOut[n] = 1'b1;
        expectBus(regModel[n]);
        endStep();
    endtask

    task automatic loadRegister(input int n, input dataWord value);
        memData = value;
        read = 1'b1;
        mdrIn = 1'b1;
        expectBus('0);
        endStep();
        mdrOut = 1'b1;
        regIn[n] = 1'b1;
        expectBus(value);
        endStep();
        regModel[n] = value;
    endtask

    task automatic runAluOp(input int a, input int b, input int c, input aluOp op);
        dataWord result;
        result = aluExpected(op, regModel[a], regModel[b]);
        regOut[a] = 1'b1;
        yIn = 1'b1;
        expectBus(regModel[a]);
        endStep();
        regOut[b] = 1'b1;
        opcode = op;
        zIn = 1'b1;
        expectBus(regModel[b]);
        endStep();
        zLowOut = 1'b1;
        regIn[c] = 1'b1;
        expectBus(result);
        endStep();
        regModel[c] = result;
        readRegister(c);
    endtask

    task automatic runMulHiLo(input int a, input int b);
        wideWord product;
        product = productOf(regModel[a], regModel[b]);
        regOut[a] = 1'b1;
        yIn = 1'b1;
        expectBus(regModel[a]);
        endStep();
        regOut[b] = 1'b1;
        opcode = opMul;
        hiIn = 1'b1;
        loIn = 1'b1;
        endStep();
        hiOut = 1'b1;
        expectBus(product[63:32]);
        endStep();
        loOut = 1'b1;
        expectBus(product[31:0]);
        endStep();
    endtask

    // Fetch T0 to T2, starting from a PC taken out of register n
    task automatic runFetch(input int n, input dataWord instruction);
        regOut[n] = 1'b1;
        pcIn = 1'b1;
        expectBus(regModel[n]);
        endStep();
        pcModel = regModel[n];
        pcOut = 1'b1;
        marIn = 1'b1;
        incPc = 1'b1;
        zIn = 1'b1;
        expectBus(pcModel);
        endStep();
        zLowOut = 1'b1;
        pcIn = 1'b1;
        read = 1'b1;
        mdrIn = 1'b1;
        memData = instruction;
        expectBus(pcModel + 32'd1);
        expAddr = pcModel;
        checkAddr = 1'b1;
        endStep();
        pcModel = pcModel + 32'd1;
        mdrOut = 1'b1;
        irIn = 1'b1;
        expectBus(instruction);
        endStep();
        pcOut = 1'b1;
        expectBus(pcModel);
        endStep();
    endtask

    // ------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------
    initial begin
        int cycle;
        void'($urandom(32'h57b2));
        Clock = 1'b0;
        rst = 1'b1;
        memData = '0;
        busErrors = 0;
        addrErrors = 0;
        expBus = '0;
        expAddr = '0;
        pcModel = '0;
        clearControls();
        for (int i = 0; i < numRegs; i++) begin
            regModel[i] = '0;
        end
        for (cycle = 0; cycle < resetCycles; cycle++) begin
            @(posedge Clock);
        end
        #driveDelay;
        rst = 1'b0;

        expectBus('0);
        endStep();
        for (int i = 0; i < numRegs; i++) begin
            readRegister(i);
        end
        for (int i = 0; i < numRegs; i++) begin
            loadRegister(i, $urandom());
            readRegister(i);
        end
        foreach (opList[k]) begin
            runAluOp($urandom_range(0, numRegs - 1), $urandom_range(0, numRegs - 1),
                     $urandom_range(0, numRegs - 1), opList[k]);
        end
        runMulHiLo($urandom_range(0, numRegs - 1), $urandom_range(0, numRegs - 1));
        runFetch($urandom_range(0, numRegs - 1), $urandom());

        $display("Errors: busValue %0d, memAddress %0d", busErrors, addrErrors);
        if (busErrors + addrErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #timeLimit;
        $display("The run did not reach its end within the time limit");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== dataPath.sv ====
module dataPath (
    input  logic                  Clock,
    input  logic                  rst,
    input  dataPathPkg::dataWord  memData,
    input  logic                  read,
    input  logic                  incPc,
    input  dataPathPkg::aluOp     opcode,
    input  dataPathPkg::regSelect regIn,
    input  dataPathPkg::regSelect regOut,
    input  logic                  pcOut,
    input  logic                  mdrOut,
    input  logic                  zHighOut,
    input  logic                  zLowOut,
    input  logic                  hiOut,
    input  logic                  loOut,
    input  logic                  pcIn,
    input  logic                  irIn,
    input  logic                  marIn,
    input  logic                  mdrIn,
    input  logic                  yIn,
    input  logic                  zIn,
    input  logic                  hiIn,
    input  logic                  loIn,
    output dataPathPkg::dataWord  busValue,
    output dataPathPkg::dataWord  memAddress
);

    import dataPathPkg::*;

    dataWord [numRegs-1:0] regValues;
    dataWord pcValue;
    dataWord mdrValue;
    dataWord yValue;
    dataWord zHigh;
    dataWord zLow;
    dataWord hiValue;
    dataWord loValue;
    wideWord aluResult;

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    registerFile regFile0 (
        .Clock     (Clock),
        .rst       (rst),
        .busValue  (busValue),
        .regIn     (regIn),
        .regValues (regValues)
    );

    specialRegisters special0 (
        .Clock      (Clock),
        .rst        (rst),
        .busValue   (busValue),
        .memData    (memData),
        .aluResult  (aluResult),
        .read       (read),
        .pcIn       (pcIn),
        .irIn       (irIn),
        .marIn      (marIn),
        .mdrIn      (mdrIn),
        .yIn        (yIn),
        .zIn        (zIn),
        .hiIn       (hiIn),
        .loIn       (loIn),
        .pcValue    (pcValue),
        .mdrValue   (mdrValue),
        .yValue     (yValue),
        .zHigh      (zHigh),
        .zLow       (zLow),
        .hiValue    (hiValue),
        .loValue    (loValue),
        .memAddress (memAddress)
    );

    // ------------------------------------------------------------
    // Compute and bus
    // ------------------------------------------------------------
    aluUnit alu0 (
        .Clock     (Clock),
        .rst       (rst),
        .zIn       (zIn),
        .yValue    (yValue),
        .busValue  (busValue),
        .opcode    (opcode),
        .incPc     (incPc),
        .aluResult (aluResult)
    );

    busMux bus0 (
        .Clock     (Clock),
        .rst       (rst),
        .regValues (regValues),
        .regOut    (regOut),
        .pcOut     (pcOut),
        .mdrOut    (mdrOut),
        .zHighOut  (zHighOut),
        .zLowOut   (zLowOut),
        .hiOut     (hiOut),
        .loOut     (loOut),
        .pcValue   (pcValue),
        .mdrValue  (mdrValue),
        .zHigh     (zHigh),
        .zLow      (zLow),
        .hiValue   (hiValue),
        .loValue   (loValue),
        .busValue  (busValue)
    );

endmodule

// ==== busMux.sv ====
module busMux (
    input  logic                                            Clock,
    input  logic                                            rst,
    input  dataPathPkg::dataWord [dataPathPkg::numRegs-1:0] regValues,
    input  dataPathPkg::regSelect                           regOut,
    input  logic                                            pcOut,
    input  logic                                            mdrOut,
    input  logic                                            zHighOut,
    input  logic                                            zLowOut,
    input  logic                                            hiOut,
    input  logic                                            loOut,
    input  dataPathPkg::dataWord                            pcValue,
    input  dataPathPkg::dataWord                            mdrValue,
    input  dataPathPkg::dataWord                            zHigh,
    input  dataPathPkg::dataWord                            zLow,
    input  dataPathPkg::dataWord                            hiValue,
    input  dataPathPkg::dataWord                            loValue,
    output dataPathPkg::dataWord                            busValue
);

    import dataPathPkg::*;

    // Each source is masked by its enable and the results are OR-ed,
    // so the bus reads zero when nothing drives it
    always_comb begin
        busValue = '0;
        for (int i = 0; i < numRegs; i++) begin
            busValue = busValue | (regValues[i] & {wordWidth{regOut[i]}});
        end
        busValue = busValue | (pcValue & {wordWidth{pcOut}});
        busValue = busValue | (mdrValue & {wordWidth{mdrOut}});
        busValue = busValue | (zHigh & {wordWidth{zHighOut}});
        busValue = busValue | (zLow & {wordWidth{zLowOut}});
        busValue = busValue | (hiValue & {wordWidth{hiOut}});
        busValue = busValue | (loValue & {wordWidth{loOut}});
    end

    singleBusSource: assert property (
        @(posedge Clock) disable iff (rst)
        $onehot0({regOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut})
    ) else $error("More than one bus source enabled");

endmodule

// ==== aluUnit.sv ====
module aluUnit (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 zIn,
    input  dataPathPkg::dataWord yValue,
    input  dataPathPkg::dataWord busValue,
    input  dataPathPkg::aluOp    opcode,
    input  logic                 incPc,
    output dataPathPkg::wideWord aluResult
);

    import dataPathPkg::*;

    logic [shiftWidth-1:0] shiftAmount;
    logic [shiftWidth:0]   rotateBack;
    dataWord               wordResult;
    wideWord               product;
    logic                  opValid;

    // Shifts and rotates use only the low bits of operand B
    assign shiftAmount = busValue[shiftWidth-1:0];
    assign rotateBack = (shiftWidth + 1)'(wordWidth) - {1'b0, shiftAmount};

    assign product = $signed(yValue) * $signed(busValue);

    // ------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------
    always_comb begin
        opValid = 1'b1;
        case (opcode)
            opAdd: wordResult = yValue + busValue;
            opSub: wordResult = yValue - busValue;
            opAnd: wordResult = yValue & busValue;
            opOr: wordResult = yValue | busValue;
            opShr: wordResult = yValue >> shiftAmount;
            opShl: wordResult = yValue << shiftAmount;
            opRor: wordResult = (yValue >> shiftAmount) | (yValue << rotateBack);
            opRol: wordResult = (yValue << shiftAmount) | (yValue >> rotateBack);
            opNeg: wordResult = -busValue;
            opNot: wordResult = ~busValue;
            opMul: wordResult = '0;
            default: begin
                wordResult = '0;
                opValid = 1'b0;
            end
        endcase
    end

    // The PC increment wins over any opcode
    always_comb begin
        if (incPc) begin
            aluResult = {{wordWidth{1'b0}}, busValue + dataWord'(1)};
        end else if (opcode == opMul) begin
            aluResult = product;
        end else begin
            aluResult = {{wordWidth{1'b0}}, wordResult};
        end
    end

    // Z must never capture the result of an unknown opcode
    knownOpcodeIntoZ: assert property (
        @(posedge Clock) disable iff (rst)
        (zIn && !incPc) |-> opValid
    ) else $error("Z loaded with unknown opcode %b", opcode);

endmodule

// ==== specialRegisters.sv ====
module specialRegisters (
    input  logic                 Clock,
    input  logic                 rst,
    input  dataPathPkg::dataWord busValue,
    input  dataPathPkg::dataWord memData,
    input  dataPathPkg::wideWord aluResult,
    input  logic                 read,
    input  logic                 pcIn,
    input  logic                 irIn,
    input  logic                 marIn,
    input  logic                 mdrIn,
    input  logic                 yIn,
    input  logic                 zIn,
    input  logic                 hiIn,
    input  logic                 loIn,
    output dataPathPkg::dataWord pcValue,
    output dataPathPkg::dataWord mdrValue,
    output dataPathPkg::dataWord yValue,
    output dataPathPkg::dataWord zHigh,
    output dataPathPkg::dataWord zLow,
    output dataPathPkg::dataWord hiValue,
    output dataPathPkg::dataWord loValue,
    output dataPathPkg::dataWord memAddress
);

    import dataPathPkg::*;

    dataWord mdrNext;

    // Memory data enters the MDR on a read, the bus otherwise
    assign mdrNext = read ? memData : busValue;

    // ------------------------------------------------------------
    // Register updates
    // ------------------------------------------------------------
    always_ff @(posedge Clock) begin
        if (rst) begin
            pcValue <= '0;
            memAddress <= '0;
            mdrValue <= '0;
            yValue <= '0;
            zHigh <= '0;
            zLow <= '0;
            hiValue <= '0;
            loValue <= '0;
        end else begin
            if (pcIn) pcValue <= busValue;
            if (marIn) memAddress <= busValue;
            if (mdrIn) mdrValue <= mdrNext;
            if (yIn) yValue <= busValue;
            if (zIn) begin
                zHigh <= aluResult[2*wordWidth-1:wordWidth];
                zLow <= aluResult[wordWidth-1:0];
            end
            if (hiIn) hiValue <= aluResult[2*wordWidth-1:wordWidth];
            if (loIn) loValue <= aluResult[wordWidth-1:0];
        end
    end

    // A memory read is only meaningful when the MDR captures it
    readNeedsMdrIn: assert property (
        @(posedge Clock) disable iff (rst)
        read |-> mdrIn
    ) else $error("read is high without mdrIn");

endmodule

// ==== registerFile.sv ====
module registerFile (
    input  logic                                          Clock,
    input  logic                                          rst,
    input  dataPathPkg::dataWord                          busValue,
    input  dataPathPkg::regSelect                         regIn,
    output dataPathPkg::dataWord [dataPathPkg::numRegs-1:0] regValues
);

    import dataPathPkg::*;

    // The sixteen general registers R0 to R15
    dataWord generalRegs [numRegs];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                generalRegs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                if (regIn[i]) begin
                    generalRegs[i] <= busValue;
                end
            end
        end
    end

    // Every register is offered to the bus multiplexer
    always_comb begin
        for (int i = 0; i < numRegs; i++) begin
            regValues[i] = generalRegs[i];
        end
    end

    // Only one register may take the bus value in a given cycle
    regInOneHot: assert property (
        @(posedge Clock) disable iff (rst)
        $onehot0(regIn)
    ) else $error("regIn has more than one bit set: %b", regIn);

endmodule

// ==== dataPathPkg.sv ====
package dataPathPkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int wordWidth = 32;
    localparam int numRegs = 16;
    localparam int opWidth = 5;
    localparam int shiftWidth = 5;

    typedef logic [wordWidth-1:0] dataWord;
    typedef logic [2*wordWidth-1:0] wideWord;

    // One bit per general register, used for both in and out enables
    typedef logic [numRegs-1:0] regSelect;

    typedef logic [opWidth-1:0] aluOp;

    // ------------------------------------------------------------
    // ALU operation codes
    // ------------------------------------------------------------
    localparam aluOp opAdd = 5'b00011;
    localparam aluOp opSub = 5'b00100;
    localparam aluOp opAnd = 5'b00101;
    localparam aluOp opOr = 5'b00110;
    localparam aluOp opShr = 5'b00111;
    localparam aluOp opShl = 5'b01001;
    localparam aluOp opRor = 5'b01010;
    localparam aluOp opRol = 5'b01011;
    localparam aluOp opMul = 5'b01110;
    localparam aluOp opNeg = 5'b10001;
    localparam aluOp opNot = 5'b10010;

endpackage
